//--- include/prefetch_config.svh
`ifndef PREFETCH_CONFIG_SVH
`define PREFETCH_CONFIG_SVH

// --------------------
// Word and run geometry
// --------------------

`define PF_WIDTH 32   // Bits per data word
`define PF_BBITS 3    // Word-in-block index bits
`define PF_BSIZE 8    // Words per block, 2**PF_BBITS
`define PF_CBITS 2    // Block index bits
`define PF_COUNT 24   // Words per run, whole blocks only

// Master and slave word address, block and word fields together
`define PF_ABITS 5

`endif

//--- source/wb_pkg.sv
`default_nettype none

`include "prefetch_config.svh"

// Field types shared by the master and slave Wishbone ports
package wb_pkg;

   // --------------------
   // Data and address
   // --------------------

   typedef logic [`PF_WIDTH-1:0] wb_dat_t;    // One bus word
   typedef logic [`PF_ABITS-1:0] wb_adr_t;    // Word address, not byte address

   // Byte lanes, one per 8 data bits
   typedef logic [`PF_WIDTH/8-1:0] wb_sel_t;

endpackage

`default_nettype wire

//--- source/prefetch_pkg.sv
`default_nettype none

`include "prefetch_config.svh"

// Prefetch-side indices and the two-way fetch address
package prefetch_pkg;

   // Blocks fetched per run
   localparam int PF_NBLOCKS = `PF_COUNT / `PF_BSIZE;

   typedef logic [`PF_CBITS-1:0] blk_idx_t;   // Block within a run
   typedef logic [`PF_BBITS-1:0] wrd_idx_t;   // Word within a block
   typedef logic [`PF_ABITS-1:0] buf_adr_t;   // Flat buffer slot

   // Block number on top, word below
   typedef struct packed {
      blk_idx_t blk;
      wrd_idx_t wrd;
   } fetch_pair_t;

   // Same bits, seen as a bus pair or as a buffer slot
   typedef union packed {
      fetch_pair_t pair;
      buf_adr_t    flat;
   } fetch_addr_u;

endpackage

// --------------------
// Sequencer to fetch unit
// --------------------
interface fetch_ctl_if;
   import prefetch_pkg::*;

   logic     start;  // One-cycle launch, only while busy is low
   blk_idx_t blk;    // Held for the whole block
   logic     busy;   // Requests or acks still outstanding
   logic     done;   // Block landed

   modport seq   (output start, output blk, input busy, input done);
   modport fetch (input start, input blk, output busy, output done);
endinterface

// --------------------
// Fetch unit to buffer
// --------------------
interface buf_wr_if;
   import prefetch_pkg::*;
   import wb_pkg::*;

   logic        we;   // Write strobe, no handshake
   fetch_addr_u adr;
   wb_dat_t     dat;
   logic        clr;  // Invalidate all words for the slave

   modport src (output we, output adr, output dat, output clr);
   modport dst (input we, input adr, input dat, input clr);
endinterface

`default_nettype wire

//--- source/prefetch_sequencer.sv
`default_nettype none

// Run control, one start per block and a ready pulse at the end
module prefetch_sequencer (
   input  wire      clk_i,
   input  wire      rst_i,
   input  wire      begin_i,  // Start, or abort and restart
   output logic     ready_o,  // Last block stored
   fetch_ctl_if.seq ctl,
   output logic     clr_o     // Buffer invalidate, one cycle
);
   import prefetch_pkg::*;

   localparam blk_idx_t LAST_BLK = blk_idx_t'(PF_NBLOCKS - 1);

   logic pending;  // Run requested, fetch unit not yet free
   logic can_go;

   // A start issued last cycle has not yet raised busy
   assign can_go = !ctl.busy && !ctl.start;

   // --------------------
   // Block counter and launch
   // --------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         pending   <= 1'b0;
         ctl.start <= 1'b0;
         ctl.blk   <= '0;
         ready_o   <= 1'b0;
         clr_o     <= 1'b0;
      end else begin
         clr_o     <= begin_i;  // Buffer and fetch see it next cycle
         ready_o   <= 1'b0;
         ctl.start <= 1'b0;

         if (begin_i) begin
            // New run wins over anything in progress
            ctl.blk   <= '0;
            ctl.start <= can_go;
            pending   <= !can_go;  // Wait out the aborted block
         end else if (pending) begin
            if (can_go) begin
               ctl.start <= 1'b1;
               pending   <= 1'b0;
            end
         end else if (ctl.done) begin
            if (ctl.blk == LAST_BLK) begin
               ready_o <= 1'b1;  // Whole run buffered
            end else begin
               ctl.blk   <= ctl.blk + 1'b1;
               ctl.start <= 1'b1;  // Next block right away
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- source/wb_block_fetch.sv
`default_nettype none

// Pipelined Wishbone read master, one block per start
module wb_block_fetch (
   input  wire               clk_i,
   input  wire               rst_i,
   fetch_ctl_if.fetch        ctl,
   buf_wr_if.src             wr,
   input  wire               clr_i,   // Run aborted
   output logic              cyc_o,
   output logic              stb_o,
   output logic              we_o,
   input  wire               ack_i,
   input  wire               wat_i,   // Stall
   output wb_pkg::wb_adr_t   adr_o,
   output wb_pkg::wb_sel_t   sel_o,
   input  wire wb_pkg::wb_dat_t dat_i
);
   import prefetch_pkg::*;

   localparam int WB = $bits(wrd_idx_t);

   // Extra top bit marks a full block
   logic [WB:0] req_cnt;   // Requests accepted
   logic [WB:0] ack_cnt;   // Acks received
   logic [WB:0] req_nxt;
   logic [WB:0] ack_nxt;
   logic        abort;     // Draining acks of a dropped run
   logic        stopping;
   logic        req_ok;
   logic        ack_ok;

   fetch_addr_u req_adr;   // Bus side, pair view
   fetch_addr_u ack_adr;   // Buffer side, flat view downstream

   assign we_o  = 1'b0;    // Read-only master
   assign sel_o = '1;      // Whole words

   assign req_ok   = stb_o && !wat_i;
   assign ack_ok   = cyc_o && ack_i;
   assign req_nxt  = req_cnt + {{WB{1'b0}}, req_ok};
   assign ack_nxt  = ack_cnt + {{WB{1'b0}}, ack_ok};
   assign stopping = abort || clr_i;

   // --------------------
   // Addresses
   // --------------------
   always_comb begin
      req_adr.pair.blk = ctl.blk;
      req_adr.pair.wrd = req_cnt[WB-1:0];  // Moves only on acceptance
      ack_adr.pair.blk = ctl.blk;
      ack_adr.pair.wrd = ack_cnt[WB-1:0];  // Acks come back in order
   end

   assign adr_o = req_adr.flat;

   // Returned words go straight to the buffer, same cycle
   assign wr.we  = ack_ok && !stopping;
   assign wr.adr = ack_adr;
   assign wr.dat = dat_i;
   assign wr.clr = clr_i;

   assign ctl.busy = cyc_o;

   // --------------------
   // Bus cycle control
   // --------------------
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         cyc_o    <= 1'b0;
         stb_o    <= 1'b0;
         abort    <= 1'b0;
         ctl.done <= 1'b0;
         req_cnt  <= '0;
         ack_cnt  <= '0;
      end else begin
         ctl.done <= 1'b0;
         if (!cyc_o) begin
            if (ctl.start) begin
               cyc_o   <= 1'b1;
               stb_o   <= 1'b1;
               abort   <= 1'b0;
               req_cnt <= '0;
               ack_cnt <= '0;
            end
         end else begin
            req_cnt <= req_nxt;
            ack_cnt <= ack_nxt;
            if (stopping) begin
               // No new requests, hold cyc until every ack is in
               abort <= 1'b1;
               stb_o <= 1'b0;
               if (req_nxt == ack_nxt) begin
                  cyc_o <= 1'b0;
                  abort <= 1'b0;  // Idle again, no done
               end
            end else begin
               if (req_nxt[WB])
                  stb_o <= 1'b0;  // All requests of the block accepted
               if (ack_nxt[WB]) begin
                  cyc_o    <= 1'b0;  // Ack counter wrapped
                  ctl.done <= 1'b1;
               end
            end
         end
      end
   end

endmodule

`default_nettype wire

//--- source/prefetch_buffer.sv
`default_nettype none

`include "prefetch_config.svh"

// Word store, written by the fetch unit, read over a Wishbone slave
module prefetch_buffer (
   input  wire                  clk_i,
   input  wire                  rst_i,
   buf_wr_if.dst                wr,
   input  wire                  cyc_i,
   input  wire                  stb_i,
   input  wire                  we_i,
   input  wire wb_pkg::wb_adr_t adr_i,
   output logic                 ack_o,
   output logic                 err_o,
   output wb_pkg::wb_dat_t      dat_o
);
   import wb_pkg::*;

   localparam wb_adr_t TOP_ADR = wb_adr_t'(`PF_COUNT);

   wb_dat_t              mem [`PF_COUNT];  // Dual-port array
   logic [`PF_COUNT-1:0] valid;            // Written since last clear
   wb_dat_t              rd_q;
   logic                 hit_q;            // Word read was valid
   logic                 access;
   logic                 bad;

   // --------------------
   // Write port
   // --------------------
   always_ff @(posedge clk_i) begin
      if (wr.we)
         mem[wr.adr.flat] <= wr.dat;  // Flat view of the fetch address
   end

   always_ff @(posedge clk_i) begin
      if (rst_i || wr.clr) begin
         valid <= '0;  // Old run no longer readable
      end else if (wr.we) begin
         valid[wr.adr.flat] <= 1'b1;
      end
   end

   // --------------------
   // Slave read port
   // --------------------
   assign access = cyc_i && stb_i;
   assign bad    = we_i || (adr_i >= TOP_ADR);  // Read-only, bounded

   always_ff @(posedge clk_i) begin
      if (access && !bad) begin
         rd_q  <= mem[adr_i];
         hit_q <= valid[adr_i];
      end
   end

   // One response per request, one cycle later
   always_ff @(posedge clk_i) begin
      if (rst_i) begin
         ack_o <= 1'b0;
         err_o <= 1'b0;
      end else begin
         ack_o <= access && !bad;
         err_o <= access && bad;
      end
   end

   // Words not yet refetched read as zero
   assign dat_o = hit_q ? rd_q : '0;

endmodule

`default_nettype wire

//--- source/wb_prefetch_top.sv
`default_nettype none

// Block prefetcher, master bus fills the buffer, slave bus drains it
module wb_prefetch_top (
   input  wire                  clk_i,
   input  wire                  rst_i,

   // Control
   input  wire                  begin_i,
   output logic                 ready_o,

   // Prefetch master
   output logic                 a_cyc_o,
   output logic                 a_stb_o,
   output logic                 a_we_o,
   input  wire                  a_ack_i,
   input  wire                  a_wat_i,
   output wb_pkg::wb_adr_t      a_adr_o,
   output wb_pkg::wb_sel_t      a_sel_o,
   input  wire wb_pkg::wb_dat_t a_dat_i,

   // Readout slave
   input  wire                  b_cyc_i,
   input  wire                  b_stb_i,
   input  wire                  b_we_i,
   input  wire wb_pkg::wb_adr_t b_adr_i,
   output logic                 b_ack_o,
   output logic                 b_err_o,
   output wb_pkg::wb_dat_t      b_dat_o
);

   logic clr;  // Run restart, sequencer to fetch unit

   fetch_ctl_if ctl_bus ();
   buf_wr_if    wr_bus ();

   // --------------------
   // Run control
   // --------------------
   prefetch_sequencer i_seq (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .begin_i (begin_i),
      .ready_o (ready_o),
      .ctl     (ctl_bus.seq),
      .clr_o   (clr)
   );

   // --------------------
   // Master side
   // --------------------
   wb_block_fetch i_fetch (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .ctl   (ctl_bus.fetch),
      .wr    (wr_bus.src),
      .clr_i (clr),
      .cyc_o (a_cyc_o),
      .stb_o (a_stb_o),
      .we_o  (a_we_o),
      .ack_i (a_ack_i),
      .wat_i (a_wat_i),
      .adr_o (a_adr_o),
      .sel_o (a_sel_o),
      .dat_i (a_dat_i)
   );

   // --------------------
   // Buffer and slave side
   // --------------------
   prefetch_buffer i_buf (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .wr    (wr_bus.dst),
      .cyc_i (b_cyc_i),
      .stb_i (b_stb_i),
      .we_i  (b_we_i),
      .adr_i (b_adr_i),
      .ack_o (b_ack_o),
      .err_o (b_err_o),
      .dat_o (b_dat_o)
   );

endmodule

`default_nettype wire

//--- bench/wb_mem_model.sv
`default_nettype none

`include "prefetch_config.svh"

// Pipelined Wishbone read slave with random stalls and ack delay
module wb_mem_model #(
   parameter int SEED_OFS = 0  // Offset on the shared LCG seed
) (
   input  wire                  clk_i,
   input  wire                  rst_i,
   input  wire                  cyc_i,
   input  wire                  stb_i,
   input  wire wb_pkg::wb_adr_t adr_i,
   output logic                 ack_o,
   output logic                 wat_o,   // Stall
   output wb_pkg::wb_dat_t      dat_o
);
   timeunit 1ns;
   timeprecision 100ps;
   import wb_pkg::*;

   localparam int WORDS = 1 << `PF_ABITS;

   wb_dat_t     mem [WORDS];
   wb_adr_t     pend_q [$];                 // Accepted requests still owed an ack
   int unsigned lcg_state = 66186 + SEED_OFS;
   int          gap;                        // Idle cycles before next ack

   function automatic int unsigned next_rand();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state >> 16;  // Upper bits spread better
   endfunction

   // Loaded by the testbench between runs
   task automatic load_word(input int adr, input wb_dat_t val);
      mem[adr] = val;
   endtask

   initial begin
      ack_o = 1'b0;
      wat_o = 1'b0;
      dat_o = '0;
      gap   = 0;
   end

   // --------------------
   // Request and response
   // --------------------
   always @(posedge clk_i) begin
      if (rst_i) begin
         pend_q.delete();
         gap = 0;
         ack_o <= #1 1'b0;
         wat_o <= #1 1'b0;
      end else begin
         if (cyc_i && stb_i && !wat_o)
            pend_q.push_back(adr_i);  // Taken on any unstalled strobe
         if (!cyc_i)
            pend_q.delete();          // Nothing owed once the cycle drops
         if (gap > 0)
            gap--;
         // Acks strictly in request order
         if (pend_q.size() > 0 && gap == 0) begin
            ack_o <= #1 1'b1;
            dat_o <= #1 mem[pend_q.pop_front()];
            gap = int'(next_rand() % 4);  // 0 to 3 idle cycles
         end else begin
            ack_o <= #1 1'b0;
         end
         wat_o <= #1 (next_rand() % 3 == 0);  // Stalls about one cycle in three
      end
   end

endmodule

`default_nettype wire

//--- bench/tb_wb_prefetch.sv
`default_nettype none

`include "prefetch_config.svh"

module tb_wb_prefetch;
   timeunit 1ns;
   timeprecision 100ps;
   import wb_pkg::*;
   import prefetch_pkg::*;

   localparam int RUNS       = 4;
   localparam int WORDS      = 1 << `PF_ABITS;                  // Slave address space
   localparam int MAX_CYCLES = RUNS * `PF_COUNT * 12 + 2000;
   localparam int ABORT_AT   = `PF_BSIZE + 3;                   // Mid second block

   logic    clk_i;
   logic    rst_i;
   logic    begin_i;
   logic    ready_o;
   logic    a_cyc_o, a_stb_o, a_we_o, a_ack_i, a_wat_i;
   wb_adr_t a_adr_o;
   wb_sel_t a_sel_o;
   wb_dat_t a_dat_i;
   logic    b_cyc_i, b_stb_i, b_we_i, b_ack_o, b_err_o;
   wb_adr_t b_adr_i;
   wb_dat_t b_dat_o;

   wb_dat_t     ref_mem [WORDS];   // Reference copy of the model memory
   int unsigned lcg_state = 66186;
   int          exp_adr;           // Next master address due
   int          acks_seen;         // Acks of the live run
   int          accepted;          // Requests since last begin
   int          ready_cnt;
   logic        ready_prev;
   logic        skip_run;          // Aborted run still draining
   int          cycles;

   wb_prefetch_top i_dut (
      .clk_i   (clk_i),
      .rst_i   (rst_i),
      .begin_i (begin_i),
      .ready_o (ready_o),
      .a_cyc_o (a_cyc_o),
      .a_stb_o (a_stb_o),
      .a_we_o  (a_we_o),
      .a_ack_i (a_ack_i),
      .a_wat_i (a_wat_i),
      .a_adr_o (a_adr_o),
      .a_sel_o (a_sel_o),
      .a_dat_i (a_dat_i),
      .b_cyc_i (b_cyc_i),
      .b_stb_i (b_stb_i),
      .b_we_i  (b_we_i),
      .b_adr_i (b_adr_i),
      .b_ack_o (b_ack_o),
      .b_err_o (b_err_o),
      .b_dat_o (b_dat_o)
   );

   wb_mem_model #(.SEED_OFS(1)) i_mem (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .cyc_i (a_cyc_o),
      .stb_i (a_stb_o),
      .adr_i (a_adr_o),
      .ack_o (a_ack_i),
      .wat_o (a_wat_i),
      .dat_o (a_dat_i)
   );

   initial clk_i = 1'b0;
   always #5 clk_i = ~clk_i;  // 10 ns period

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("ERR %s: got %h, expected %h", name, got, exp);
         $display("Errors found");
         $fatal(1, "value mismatch");
      end
   endtask

   function automatic int unsigned lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   // Fresh contents in the model and the reference
   task automatic fill_memory();
      wb_dat_t val;
      for (int a = 0; a < WORDS; a++) begin
         val = lcg_next();
         ref_mem[a] = val;
         i_mem.load_word(a, val);
      end
   endtask

   task automatic pulse_begin();
      begin_i   = 1'b1;
      exp_adr   = 0;
      acks_seen = 0;
      accepted  = 0;
      @(posedge clk_i);
      #1;
      begin_i = 1'b0;
   endtask

   task automatic wait_ready(input int n);
      while (ready_cnt < n) begin
         @(posedge clk_i);
         #1;
      end
   endtask

   // One classic cycle with the response sampled one edge later
   task automatic slave_access(input logic we, input int adr,
                               output logic ack, output logic err, output wb_dat_t dat);
      b_cyc_i = 1'b1;
      b_stb_i = 1'b1;
      b_we_i  = we;
      b_adr_i = wb_adr_t'(adr);
      @(posedge clk_i);
      check("b_ack_o before response cycle", b_ack_o, 1'b0);
      check("b_err_o before response cycle", b_err_o, 1'b0);
      #1;
      b_cyc_i = 1'b0;
      b_stb_i = 1'b0;
      b_we_i  = 1'b0;
      @(posedge clk_i);
      ack = b_ack_o;
      err = b_err_o;
      dat = b_dat_o;
      #1;
   endtask

   task automatic read_word(input int adr);
      logic    ack;
      logic    err;
      wb_dat_t dat;
      slave_access(1'b0, adr, ack, err, dat);
      check("b_ack_o", ack, 1'b1);
      check("b_err_o", err, 1'b0);
      check("b_dat_o", dat, ref_mem[adr]);
   endtask

   task automatic expect_error(input logic we, input int adr);
      logic    ack;
      logic    err;
      wb_dat_t dat;
      slave_access(we, adr, ack, err, dat);
      check("b_err_o", err, 1'b1);
      check("b_ack_o", ack, 1'b0);
   endtask

   // --------------------
   // Master bus monitor
   // --------------------
   always @(posedge clk_i) begin
      if (!rst_i) begin
         if (skip_run && !a_cyc_o) begin
            skip_run  = 1'b0;  // Restarted run begins at zero once the drain is over
            exp_adr   = 0;
            acks_seen = 0;
         end
         if (a_cyc_o && a_stb_o && !a_wat_i) begin
            check("a_we_o", a_we_o, 1'b0);
            check("a_sel_o", a_sel_o, wb_sel_t'('1));
            if (!skip_run) begin
               check("a_adr_o", a_adr_o, exp_adr);  // Strictly increasing so never twice
               exp_adr++;
            end
            accepted++;
         end
         if (a_cyc_o && a_ack_i && !skip_run)
            acks_seen++;
         if (ready_o) begin
            check("ready_o width", ready_prev, 1'b0);
            check("acks before ready_o", acks_seen, `PF_COUNT);
            ready_cnt++;
         end
         ready_prev = ready_o;
      end
   end

   initial begin
      cycles = 0;
      while (cycles < MAX_CYCLES) begin
         @(posedge clk_i);
         cycles++;
      end
      $display("Timeout: no finish within %0d cycles", MAX_CYCLES);
      $display("Errors found");
      $fatal(1, "timeout");
   end

   // --------------------
   // Stimulus
   // --------------------
   initial begin
      int run;
      int i;
      rst_i      = 1'b1;
      begin_i    = 1'b0;
      b_cyc_i    = 1'b0;
      b_stb_i    = 1'b0;
      b_we_i     = 1'b0;
      b_adr_i    = '0;
      exp_adr    = 0;
      acks_seen  = 0;
      accepted   = 0;
      ready_cnt  = 0;
      ready_prev = 1'b0;
      skip_run   = 1'b0;
      repeat (10) @(posedge clk_i);
      #1;
      rst_i = 1'b0;
      check("ready_o", ready_o, 1'b0);
      check("a_cyc_o", a_cyc_o, 1'b0);
      check("a_stb_o", a_stb_o, 1'b0);

      for (run = 0; run < RUNS; run++) begin
         fill_memory();
         pulse_begin();
         if (run == 2) begin
            // Restart mid block with new contents
            while (accepted < ABORT_AT) begin
               @(posedge clk_i);
               #1;
            end
            fill_memory();
            skip_run = 1'b1;
            pulse_begin();
         end
         wait_ready(run + 1);
         for (i = 0; i < `PF_COUNT; i++)
            read_word(i);
         for (i = 0; i < 16; i++)
            read_word((lcg_next() >> 16) % `PF_COUNT);
         for (i = 0; i < 4; i++) begin
            expect_error(1'b1, (lcg_next() >> 16) % WORDS);  // Any write
            expect_error(1'b0, `PF_COUNT + (lcg_next() >> 16) % (WORDS - `PF_COUNT));
         end
         check("ready_o count", ready_cnt, run + 1);  // Exactly one per run
      end

      $display("No errors");
      $finish;
   end

endmodule

`default_nettype wire

//--- all.f
+incdir+include
source/wb_pkg.sv
source/prefetch_pkg.sv
source/prefetch_sequencer.sv
source/wb_block_fetch.sv
source/prefetch_buffer.sv
source/wb_prefetch_top.sv
bench/wb_mem_model.sv
bench/tb_wb_prefetch.sv

//--- Bender.yml
package:
  name: wb_prefetch

sources:
  - include_dirs:
      - include
    files:
      - source/wb_pkg.sv
      - source/prefetch_pkg.sv
      - source/prefetch_sequencer.sv
      - source/wb_block_fetch.sv
      - source/prefetch_buffer.sv
      - source/wb_prefetch_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - bench/wb_mem_model.sv
      - bench/tb_wb_prefetch.sv
